// ==== Bender.yml ====
package:
  name: icache

sources:
  - include_dirs:
      - .
    files:
      - icachePkg.sv
      - tagStore.sv
      - dataStore.sv
      - lookupStage.sv
      - refillStage.sv
      - icacheTop.sv
      - target: test
        files:
          - tbIcache.sv

// ==== dataStore.sv ====
`timescale 1ns/1ns
`include "icache_config.svh"

module dataStore (
  input  logic                        clk,
  input  logic [`ICACHE_INDEX_W-1:0]  rdIndex,
  input  logic                        lineWe,
  input  logic                        lineWay,
  input  logic [`ICACHE_INDEX_W-1:0]  lineIndex,
  input  logic [`ICACHE_LINE_W-1:0]   lineData,
  output logic [`ICACHE_LINE_W-1:0]   lineData0,
  output logic [`ICACHE_LINE_W-1:0]   lineData1
);

  // behavioral line array, way by set
  logic [`ICACHE_LINE_W-1:0] lineMem [`ICACHE_WAYS][`ICACHE_SETS];

  // whole line written at once from the refill buffer
  always_ff @(posedge clk) begin
    if (lineWe) begin
      lineMem[lineWay][lineIndex] <= lineData;
    end
  end

  // both ways read every cycle
  // the hit select happens one stage later
  always_ff @(posedge clk) begin
    lineData0 <= lineMem[0][rdIndex];
    lineData1 <= lineMem[1][rdIndex];
  end

endmodule

// ==== filelist.f ====
+incdir+.
icachePkg.sv
tagStore.sv
dataStore.sv
lookupStage.sv
refillStage.sv
icacheTop.sv
tbIcache.sv

// ==== icachePkg.sv ====
`include "icache_config.svh"

package icachePkg;

  // address split as seen by the cache
  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0]    tag;
    logic [`ICACHE_INDEX_W-1:0]  index;
    logic [`ICACHE_OFFSET_W-1:0] offset;
  } icacheAddrFieldsT;

  // same word, raw or decoded
  typedef union packed {
    logic [`ICACHE_ADDR_W-1:0] raw;
    icacheAddrFieldsT          fields;
  } icacheAddrT;

  // one way of one set
  typedef struct packed {
    logic                     valid;
    logic [`ICACHE_TAG_W-1:0] tag;
  } tagEntryT;

endpackage

// ==== icacheTop.sv ====
`timescale 1ns/1ns
`include "icache_config.svh"

module icacheTop (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        valid_i,
  input  logic [`ICACHE_ADDR_W-1:0]   addr_i,
  output logic                        addrOk_o,
  output logic                        dataOk_o,
  output logic [`ICACHE_XLEN-1:0]     rdData_o,
  output logic                        memRdValid_o,
  output logic [`ICACHE_ADDR_W-1:0]   memAddr_o,
  input  logic                        memCredit_i,
  input  logic [`ICACHE_XLEN-1:0]     memData_i,
  input  logic                        memDataValid_i,
  input  logic                        memLast_i
);

  // stage links
  logic                        way0Hit;
  logic                        way1Hit;
  logic                        victimWay;
  logic                        missReq;
  logic                        refillDone;
  logic                        useHit;
  logic                        useWay;
  logic                        lineWe;
  logic                        lineWay;
  logic [`ICACHE_INDEX_W-1:0]  rdIndex;
  logic [`ICACHE_INDEX_W-1:0]  lineIndex;
  logic [`ICACHE_LINE_W-1:0]   lineData0;
  logic [`ICACHE_LINE_W-1:0]   lineData1;
  logic [`ICACHE_LINE_W-1:0]   lineData;
  icachePkg::icacheAddrT       missAddr;
  icachePkg::tagEntryT         lineTag;

  lookupStage uLookup (.*);

  // compare tag is the held compare-stage address
  tagStore uTagStore (.*, .cmpTag(missAddr.fields.tag));

  dataStore uDataStore (.*);

  refillStage uRefill (.*);

endmodule

// ==== icache_config.svh ====
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// core address and fetch word
`define ICACHE_ADDR_W 32
`define ICACHE_XLEN 64

// cache geometry
`define ICACHE_SETS 64
`define ICACHE_WAYS 2
`define ICACHE_BEATS 4

// outstanding line reads the memory side can hold
`define ICACHE_MEM_CREDITS 2

// derived widths
`define ICACHE_LINE_W (`ICACHE_XLEN * `ICACHE_BEATS)
`define ICACHE_OFFSET_W $clog2(`ICACHE_LINE_W / 8)
`define ICACHE_INDEX_W $clog2(`ICACHE_SETS)
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

`endif

// ==== icache_golden.txt ====
# name  address  expected word {A, ~A}  hit (1 = no memory read)  hold
# hold delays the credit return of that test's refill by so many cycles
cold0     00001000 00001000ffffefff 0 0
cold8     00001028 00001028ffffefd7 0 0
cold16    00001050 00001050ffffefaf 0 0
cold24    00001078 00001078ffffef87 0 0
rep0      00001000 00001000ffffefff 1 0
rep8      00001008 00001008ffffeff7 1 0
rep16     00001010 00001010ffffefef 1 0
rep24     00001018 00001018ffffefe7 1 0
rep1020   00001020 00001020ffffefdf 1 0
rep1058   00001058 00001058ffffefa7 1 0
setA      000080a0 000080a0ffff7f5f 0 0
setB      000100a0 000100a0fffeff5f 0 0
setAhit   000080a8 000080a8ffff7f57 1 0
setC      000180a0 000180a0fffe7f5f 0 0
setAkeep  000080b0 000080b0ffff7f4f 1 0
setBback  000100b8 000100b8fffeff47 0 0
setCback  000180a8 000180a8fffe7f57 0 0
setBhit   000100a0 000100a0fffeff5f 1 0
setAback  000080a0 000080a0ffff7f5f 0 0
setBstay  000100b0 000100b0fffeff4f 1 0
credA     00002000 00002000ffffdfff 0 120
credB     00002048 00002048ffffdfb7 0 120
credC     00002090 00002090ffffdf6f 0 0
credAhit  00002008 00002008ffffdff7 1 0
credChit  00002098 00002098ffffdf67 1 0
last0     00001018 00001018ffffefe7 1 0

// ==== lookupStage.sv ====
`timescale 1ns/1ns
`include "icache_config.svh"

module lookupStage (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        valid_i,
  input  logic [`ICACHE_ADDR_W-1:0]   addr_i,
  input  logic                        way0Hit,
  input  logic                        way1Hit,
  input  logic [`ICACHE_LINE_W-1:0]   lineData0,
  input  logic [`ICACHE_LINE_W-1:0]   lineData1,
  input  logic                        refillDone,
  output logic                        addrOk_o,
  output logic                        dataOk_o,
  output logic [`ICACHE_XLEN-1:0]     rdData_o,
  output logic [`ICACHE_INDEX_W-1:0]  rdIndex,
  output logic                        missReq,
  output icachePkg::icacheAddrT       missAddr,
  output logic                        useHit,
  output logic                        useWay
);

  // low offset bits address bytes inside one word
  localparam int WORD_LSB = $clog2(`ICACHE_XLEN / 8);

  icachePkg::icacheAddrT                  reqAddr;
  icachePkg::icacheAddrT                  cmpAddr;
  logic                                   cmpValid;
  logic                                   cmpHit;
  logic                                   cmpMiss;
  logic                                   accept;
  logic                                   replay;
  logic [`ICACHE_OFFSET_W-WORD_LSB-1:0]   wordSel;
  logic [`ICACHE_LINE_W-1:0]              hitLine;
  logic [`ICACHE_XLEN-1:0]                hitWord;

  assign reqAddr.raw = addr_i;
  assign cmpHit      = way0Hit | way1Hit;
  assign cmpMiss     = cmpValid & ~cmpHit;

  // closed while a miss is seen, refilled or replayed
  assign addrOk_o = ~(missReq | replay | cmpMiss);
  assign accept   = valid_i & addrOk_o;

  // stores keep reading the compare set when nothing new enters
  assign rdIndex = accept ? reqAddr.fields.index : cmpAddr.fields.index;

  // request stage register, also the replay source
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmpValid <= 1'b0;
      cmpAddr  <= '0;
    end else begin
      cmpValid <= accept | replay;
      if (accept) begin
        cmpAddr <= reqAddr;
      end
    end
  end

  // word pick from the hitting way
  assign hitLine = way1Hit ? lineData1 : lineData0;
  assign wordSel = cmpAddr.fields.offset[`ICACHE_OFFSET_W-1:WORD_LSB];
  assign hitWord = hitLine[wordSel*`ICACHE_XLEN +: `ICACHE_XLEN];

  // miss stays open until the line is written
  // replay one cycle later so the read sees the new line
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dataOk_o <= 1'b0;
      missReq  <= 1'b0;
      replay   <= 1'b0;
    end else begin
      dataOk_o <= cmpValid & cmpHit;
      replay   <= missReq & refillDone;
      if (cmpMiss) begin
        missReq <= 1'b1;
      end else if (refillDone) begin
        missReq <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmpValid & cmpHit) begin
      rdData_o <= hitWord;
    end
  end

  assign missAddr = cmpAddr;
  assign useHit   = cmpValid & cmpHit;
  assign useWay   = way1Hit;

  // response and open miss come from exclusive compare outcomes
  noDataInMiss: assert property (@(posedge clk) disable iff (!rst_n)
    !(dataOk_o && missReq));

endmodule

// ==== refillStage.sv ====
`timescale 1ns/1ns
`include "icache_config.svh"

module refillStage (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        missReq,
  input  icachePkg::icacheAddrT       missAddr,
  input  logic                        victimWay,
  input  logic                        memCredit_i,
  input  logic [`ICACHE_XLEN-1:0]     memData_i,
  input  logic                        memDataValid_i,
  input  logic                        memLast_i,
  output logic                        memRdValid_o,
  output logic [`ICACHE_ADDR_W-1:0]   memAddr_o,
  output logic                        lineWe,
  output logic                        lineWay,
  output logic [`ICACHE_INDEX_W-1:0]  lineIndex,
  output icachePkg::tagEntryT         lineTag,
  output logic [`ICACHE_LINE_W-1:0]   lineData,
  output logic                        refillDone
);

  localparam int CREDIT_W = $clog2(`ICACHE_MEM_CREDITS + 1);
  localparam int BEAT_W   = $clog2(`ICACHE_BEATS);

  // controller states
  localparam logic [1:0] ST_WAIT    = 2'd0;
  localparam logic [1:0] ST_COLLECT = 2'd1;
  localparam logic [1:0] ST_WRITE   = 2'd2;

  logic [1:0]                 state;
  logic [CREDIT_W-1:0]        credits;
  logic [BEAT_W-1:0]          beatCnt;
  logic [`ICACHE_LINE_W-1:0]  lineBuf;
  logic                       wayQ;
  logic                       issue;
  icachePkg::icacheAddrT      lineAddr;

  // one read per miss, only with a credit in hand
  assign issue        = (state == ST_WAIT) && missReq && (credits != '0);
  assign memRdValid_o = issue;

  // line aligned request address
  always_comb begin
    lineAddr              = missAddr;
    lineAddr.fields.offset = '0;
  end
  assign memAddr_o = lineAddr.raw;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_WAIT;
      beatCnt <= '0;
      wayQ    <= 1'b0;
    end else begin
      case (state)
        ST_WAIT: begin
          // victim fixed at issue time
          if (issue) begin
            state   <= ST_COLLECT;
            wayQ    <= victimWay;
            beatCnt <= '0;
          end
        end
        ST_COLLECT: begin
          if (memDataValid_i) begin
            beatCnt <= beatCnt + 1'b1;
            if (memLast_i) begin
              state <= ST_WRITE;
            end
          end
        end
        ST_WRITE: state <= ST_WAIT;
        default:  state <= ST_WAIT;
      endcase
    end
  end

  // beats arrive in address order
  always_ff @(posedge clk) begin
    if ((state == ST_COLLECT) && memDataValid_i) begin
      lineBuf[beatCnt*`ICACHE_XLEN +: `ICACHE_XLEN] <= memData_i;
    end
  end

  // spend on issue, refund on each returned pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= CREDIT_W'(`ICACHE_MEM_CREDITS);
    end else begin
      credits <= credits - CREDIT_W'(issue) + CREDIT_W'(memCredit_i);
    end
  end

  // write pulse doubles as done, lookup replays after it
  assign lineWe        = (state == ST_WRITE);
  assign refillDone    = (state == ST_WRITE);
  assign lineWay       = wayQ;
  assign lineIndex     = missAddr.fields.index;
  assign lineTag.valid = 1'b1;
  assign lineTag.tag   = missAddr.fields.tag;
  assign lineData      = lineBuf;

  // memory must not return more than it was given
  creditBound: assert property (@(posedge clk) disable iff (!rst_n)
    credits <= CREDIT_W'(`ICACHE_MEM_CREDITS));

  // a spent credit stays out until memory hands it back
  noReqDry: assert property (@(posedge clk) disable iff (!rst_n)
    memRdValid_o |=> (credits < CREDIT_W'(`ICACHE_MEM_CREDITS)));

endmodule

// ==== tagStore.sv ====
`timescale 1ns/1ns
`include "icache_config.svh"

module tagStore (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`ICACHE_INDEX_W-1:0]  rdIndex,
  input  logic [`ICACHE_TAG_W-1:0]    cmpTag,
  input  logic                        lineWe,
  input  logic                        lineWay,
  input  logic [`ICACHE_INDEX_W-1:0]  lineIndex,
  input  icachePkg::tagEntryT         lineTag,
  input  logic                        useHit,
  input  logic                        useWay,
  output logic                        way0Hit,
  output logic                        way1Hit,
  output logic                        victimWay
);

  icachePkg::tagEntryT           tagWay0 [`ICACHE_SETS];
  icachePkg::tagEntryT           tagWay1 [`ICACHE_SETS];
  icachePkg::tagEntryT           rdEntry0;
  icachePkg::tagEntryT           rdEntry1;
  logic [`ICACHE_INDEX_W-1:0]    cmpIndex;
  // one bit per set, names the least recently used way
  logic [`ICACHE_SETS-1:0]       lruBits;

  // tag arrays, cleared so every line starts invalid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `ICACHE_SETS; i++) begin
        tagWay0[i] <= '0;
        tagWay1[i] <= '0;
      end
    end else if (lineWe) begin
      if (lineWay) begin
        tagWay1[lineIndex] <= lineTag;
      end else begin
        tagWay0[lineIndex] <= lineTag;
      end
    end
  end

  // registered read, lines up with the compare stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdEntry0 <= '0;
      rdEntry1 <= '0;
      cmpIndex <= '0;
    end else begin
      rdEntry0 <= tagWay0[rdIndex];
      rdEntry1 <= tagWay1[rdIndex];
      cmpIndex <= rdIndex;
    end
  end

  // used or filled way becomes most recent
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lruBits <= '0;
    end else if (lineWe) begin
      lruBits[lineIndex] <= ~lineWay;
    end else if (useHit) begin
      lruBits[cmpIndex] <= ~useWay;
    end
  end

  assign way0Hit   = rdEntry0.valid && (rdEntry0.tag == cmpTag);
  assign way1Hit   = rdEntry1.valid && (rdEntry1.tag == cmpTag);
  // index is held on the missing set while the miss is open
  assign victimWay = lruBits[cmpIndex];

  // a fill only happens after a miss, so a tag never sits in both ways
  oneWayHit: assert property (@(posedge clk) disable iff (!rst_n)
    !(way0Hit && way1Hit));

endmodule

// ==== tbIcache.sv ====
`timescale 1ns/1ns
`include "icache_config.svh"

module tbIcache;

  localparam int MAX_TESTS = 64;

  logic                       clk = 1'b0;
  logic                       rst_n;
  logic                       valid_i;
  logic [`ICACHE_ADDR_W-1:0]  addr_i;
  logic                       addrOk_o;
  logic                       dataOk_o;
  logic [`ICACHE_XLEN-1:0]    rdData_o;
  logic                       memRdValid_o;
  logic [`ICACHE_ADDR_W-1:0]  memAddr_o;
  logic                       memCredit_i;
  logic [`ICACHE_XLEN-1:0]    memData_i;
  logic                       memDataValid_i;
  logic                       memLast_i;

  // golden table, one entry per test
  string                      tName [MAX_TESTS];
  logic [`ICACHE_ADDR_W-1:0]  tAddr [MAX_TESTS];
  logic [`ICACHE_XLEN-1:0]    tWord [MAX_TESTS];
  int                         tHit  [MAX_TESTS];
  int                         tHold [MAX_TESTS];
  bit                         tBad  [MAX_TESTS];

  // accepted requests still waiting for dataOk_o
  int pendIdx[$];
  int pendCycle[$];
  int pendReqs[$];
  // cycles at which held credits go back
  int creditDue[$];

  // memory model state
  logic [`ICACHE_ADDR_W-1:0]  memLine;
  logic [`ICACHE_ADDR_W-1:0]  beatAddr;
  int memState = 0;
  int delayCnt, beatIdx, memHold, dueAt;
  int tbCredits = `ICACHE_MEM_CREDITS;
  integer seed;

  int testCount = 0, issueIdx = 0, doneCount = 0, passCount = 0, failCount = 0;
  int errCount = 0, cycleCnt = 0, cycleLimit = 0, reqCount = 0;
  int b2bCount = 0, stallCycles = 0;
  bit running = 1'b0;
  bit prevOk = 1'b0;

  always #5 clk = ~clk;

  icacheTop UUT (.*);

  task automatic loadGolden();
    int fd;
    int n;
    string line;
    string nm;
    logic [`ICACHE_ADDR_W-1:0] a;
    logic [`ICACHE_XLEN-1:0] w;
    int h;
    int hd;
    fd = $fopen("icache_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open icache_golden.txt");
      return;
    end
    while (!$feof(fd) && testCount < MAX_TESTS) begin
      line = "";
      n = $fgets(line, fd);
      // column notes and blank lines carry no test
      if (line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%s %h %h %d %d", nm, a, w, h, hd);
        if (n == 5) begin
          tName[testCount] = nm;
          tAddr[testCount] = a;
          tWord[testCount] = w;
          tHit[testCount]  = h;
          tHold[testCount] = hd;
          tBad[testCount]  = 1'b0;
          testCount++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic checkResponse();
    int idx;
    int lat;
    int gotHit;
    idx    = pendIdx.pop_front();
    lat    = cycleCnt - pendCycle.pop_front();
    // a hit costs no memory read
    gotHit = (reqCount == pendReqs.pop_front());
    assert (gotHit == tHit[idx]) else begin
      $display("ERR %0s hit expected %0d actual %0d", tName[idx], tHit[idx], gotHit);
      tBad[idx] = 1'b1;
    end
    // hit answers two falling edges after it was offered
    assert (!gotHit || lat == 2) else begin
      $display("ERR %0s hit latency expected 2 actual %0d", tName[idx], lat);
      tBad[idx] = 1'b1;
    end
    assert (rdData_o == tWord[idx]) else begin
      $display("ERR %0s word expected %h actual %h", tName[idx], tWord[idx], rdData_o);
      tBad[idx] = 1'b1;
    end
    if (tBad[idx]) begin
      failCount++;
    end else begin
      passCount++;
    end
    $display("%0s addr %h hit %0d cycles %0d %0s", tName[idx], tAddr[idx], gotHit, lat,
             tBad[idx] ? "bad" : "ok");
    doneCount++;
  endtask

  // memory model, core driver and monitor share one falling edge
  always @(negedge clk) begin
    if (running) begin
      cycleCnt++;
      memDataValid_i = 1'b0;
      memLast_i      = 1'b0;
      memCredit_i    = 1'b0;
      if (dataOk_o) begin
        if (prevOk) begin
          b2bCount++;
        end
        if (pendIdx.size() == 0) begin
          $display("dataOk_o pulsed with no request outstanding");
          errCount++;
        end else begin
          checkResponse();
        end
      end
      prevOk = dataOk_o;
      // line read, spends one credit
      if (memRdValid_o) begin
        assert (tbCredits > 0 && pendIdx.size() > 0) else begin
          $display("memory read issued with no credit left or no miss open");
          errCount++;
        end
        if (pendIdx.size() > 0) begin
          assert (memAddr_o == (tAddr[pendIdx[0]] & ~32'h1f)) else begin
            $display("ERR %0s memAddr expected %h actual %h", tName[pendIdx[0]],
                     tAddr[pendIdx[0]] & ~32'h1f, memAddr_o);
            tBad[pendIdx[0]] = 1'b1;
          end
          memHold = tHold[pendIdx[0]];
        end
        tbCredits--;
        reqCount++;
        memLine  = memAddr_o;
        delayCnt = 1 + ($unsigned($random(seed)) % 6);
        memState = 1;
      end
      if (memState == 1 && delayCnt > 0) begin
        delayCnt--;
      end else if (memState == 1) begin
        memState = 2;
        beatIdx  = 0;
      end
      // beats in address order, each beat is {A, ~A}
      if (memState == 2) begin
        beatAddr       = memLine + 8 * beatIdx;
        memData_i      = {beatAddr, ~beatAddr};
        memDataValid_i = 1'b1;
        memLast_i      = (beatIdx == `ICACHE_BEATS - 1);
        if (memLast_i) begin
          creditDue.push_back(cycleCnt + 1 + memHold);
          memState = 0;
        end
        beatIdx++;
      end
      // at most one credit pulse per cycle
      dueAt = -1;
      for (int k = creditDue.size() - 1; k >= 0; k--) begin
        if (creditDue[k] <= cycleCnt) begin
          dueAt = k;
        end
      end
      if (dueAt >= 0) begin
        creditDue.delete(dueAt);
        memCredit_i = 1'b1;
        tbCredits++;
      end
      // open miss keeps the core side closed
      if (pendIdx.size() > 0 && cycleCnt - pendCycle[0] >= 2 &&
          (reqCount == pendReqs[0] || memState != 0)) begin
        assert (!addrOk_o) else begin
          $display("addrOk_o high while the miss of %0s is open", tName[pendIdx[0]]);
          errCount++;
        end
        if (tbCredits == 0 && reqCount == pendReqs[0]) begin
          stallCycles++;
        end
      end
      // taken at the coming edge when addrOk_o is high
      valid_i = (issueIdx < testCount);
      if (issueIdx < testCount) begin
        addr_i = tAddr[issueIdx];
        if (addrOk_o) begin
          pendIdx.push_back(issueIdx);
          pendCycle.push_back(cycleCnt);
          pendReqs.push_back(reqCount);
          issueIdx++;
        end
      end
    end
  end

  initial begin
    seed           = 32'h112b_1c04;
    rst_n          = 1'b0;
    valid_i        = 1'b0;
    addr_i         = '0;
    memCredit_i    = 1'b0;
    memData_i      = '0;
    memDataValid_i = 1'b0;
    memLast_i      = 1'b0;
    loadGolden();
    if (testCount == 0) begin
      $display("no tests read from icache_golden.txt");
      errCount++;
    end else begin
      // worst case per test incl. one refill and a held credit
      cycleLimit = 40 * testCount;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
      assert (addrOk_o && !dataOk_o && !memRdValid_o) else begin
        $display("core or memory outputs wrong after reset");
        errCount++;
      end
      @(posedge clk);
      running = 1'b1;
      while (doneCount < testCount && cycleCnt < cycleLimit) begin
        @(posedge clk);
      end
      if (doneCount < testCount) begin
        $display("timeout after %0d cycles, %0d of %0d tests done", cycleCnt, doneCount,
                 testCount);
        errCount++;
      end
      if (b2bCount == 0) begin
        $display("no back-to-back responses were seen");
        errCount++;
      end
      if (stallCycles == 0) begin
        $display("no miss ever waited for a returned credit");
        errCount++;
      end
    end
    $display("tests %0d passed %0d failed %0d other errors %0d", testCount, passCount,
             failCount, errCount);
    if (errCount == 0 && failCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
